// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    // datapath and memory sizes
    localparam int xlen = 32;
    localparam int imem_depth = 64;
    localparam int dmem_depth = 64;
    localparam int imem_aw = $clog2(imem_depth);
    localparam int dmem_aw = $clog2(dmem_depth);

    // retire trace widths
    localparam int cycle_w = 16;
    localparam int seq_w = 8;

    // major opcodes of the supported subset
    localparam logic [6:0] op_rtype = 7'b0110011;
    localparam logic [6:0] op_itype = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3, sub is funct7 bit 5 on top of f3_add
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    //////////////////////////////////////////////////////////////////////
    // instruction word views
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } i_fmt_t;

    // store layout, beq scatters its offset over the same two fields
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef union packed {
        logic [xlen-1:0] word;
        r_fmt_t r_view;
        i_fmt_t i_view;
        s_fmt_t s_view;
    } instr_u;

endpackage

`default_nettype wire

// ==== fetch/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input logic [cpu_pkg::xlen-1:0] branch_target,
    input logic prog_we,
    input logic [cpu_pkg::imem_aw-1:0] prog_addr,
    input cpu_pkg::instr_u prog_data,
    output logic ifid_valid,
    output logic [cpu_pkg::xlen-1:0] ifid_pc,
    output cpu_pkg::instr_u ifid_instr
);

    cpu_pkg::instr_u imem [0:cpu_pkg::imem_depth-1];
    logic [cpu_pkg::xlen-1:0] pc;
    logic [cpu_pkg::imem_aw-1:0] pc_idx;

    // word index, pc is always word aligned
    assign pc_idx = pc[cpu_pkg::imem_aw+1:2];

    // program load, only open while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // pc and if/id valid
    // flush wins over stall
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            ifid_valid <= 1'b0;
        end else if (flush) begin
            pc <= branch_target;
            ifid_valid <= 1'b0;
        end else if (!stall) begin
            pc <= pc + cpu_pkg::xlen'(4);
            ifid_valid <= 1'b1;
        end
    end

    // if/id payload, held while decode stalls
    always_ff @(posedge clk) begin
        if (!stall) begin
            ifid_pc <= pc;
            ifid_instr <= imem[pc_idx];
        end
    end

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic ifid_valid,
    input logic [cpu_pkg::xlen-1:0] ifid_pc,
    input cpu_pkg::instr_u ifid_instr,
    input logic memwb_valid,
    input logic memwb_we,
    input logic [4:0] memwb_rd,
    input logic [cpu_pkg::xlen-1:0] memwb_wdata,
    input logic exmem_valid,
    input logic exmem_we,
    input logic [4:0] exmem_rd,
    output logic stall,
    output logic idex_valid,
    output logic [cpu_pkg::xlen-1:0] idex_pc,
    output logic [cpu_pkg::xlen-1:0] idex_instr,
    output logic [cpu_pkg::xlen-1:0] idex_a,
    output logic [cpu_pkg::xlen-1:0] idex_b,
    output logic [cpu_pkg::xlen-1:0] idex_imm,
    output logic [4:0] idex_rd,
    output logic idex_we,
    output logic idex_mem_rd,
    output logic idex_mem_wr
);

    logic [cpu_pkg::xlen-1:0] regs [0:31];
    logic [6:0] opcode;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic uses_rs2;
    logic is_we;
    logic is_load;
    logic is_store;
    logic [cpu_pkg::xlen-1:0] imm;
    logic [cpu_pkg::xlen-1:0] rs1_val;
    logic [cpu_pkg::xlen-1:0] rs2_val;

    // register read, x0 is zero, writeback value passes straight through
    function automatic logic [cpu_pkg::xlen-1:0] rf_read(input logic [4:0] ra);
        if (ra == 5'd0) begin
            return '0;
        end
        if (memwb_valid && memwb_we && memwb_rd == ra) begin
            return memwb_wdata;
        end
        return regs[ra];
    endfunction

    // pending write to ra anywhere downstream
    function automatic logic busy(input logic [4:0] ra);
        return (ra != 5'd0) &&
            ((idex_valid && idex_we && idex_rd == ra) ||
             (exmem_valid && exmem_we && exmem_rd == ra) ||
             (memwb_valid && memwb_we && memwb_rd == ra));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // field decode
    //////////////////////////////////////////////////////////////////////

    assign opcode = ifid_instr.r_view.opcode;
    assign rs1 = ifid_instr.r_view.rs1;
    assign rs2 = ifid_instr.r_view.rs2;

    always_comb begin
        is_load = (opcode == cpu_pkg::op_load);
        is_store = (opcode == cpu_pkg::op_store);
        is_we = (opcode == cpu_pkg::op_rtype) || (opcode == cpu_pkg::op_itype) || is_load;
        // rs1 is read by every supported opcode
        uses_rs2 = (opcode == cpu_pkg::op_rtype) || is_store ||
            (opcode == cpu_pkg::op_branch);
        case (opcode)
            cpu_pkg::op_itype, cpu_pkg::op_load: begin
                imm = {{(cpu_pkg::xlen-12){ifid_instr.i_view.imm[11]}},
                    ifid_instr.i_view.imm};
            end
            cpu_pkg::op_store: begin
                imm = {{(cpu_pkg::xlen-12){ifid_instr.s_view.imm_hi[6]}},
                    ifid_instr.s_view.imm_hi, ifid_instr.s_view.imm_lo};
            end
            cpu_pkg::op_branch: begin
                // b-type offset, bit 0 implied zero
                imm = {{(cpu_pkg::xlen-12){ifid_instr.s_view.imm_hi[6]}},
                    ifid_instr.s_view.imm_lo[0], ifid_instr.s_view.imm_hi[5:0],
                    ifid_instr.s_view.imm_lo[4:1], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    assign rs1_val = rf_read(rs1);
    assign rs2_val = rf_read(rs2);

    // raw hazard, no forwarding
    assign stall = ifid_valid && (busy(rs1) || (uses_rs2 && busy(rs2)));

    // register file write from writeback
    always_ff @(posedge clk) begin
        if (memwb_valid && memwb_we && memwb_rd != 5'd0) begin
            regs[memwb_rd] <= memwb_wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // id/ex register
    //////////////////////////////////////////////////////////////////////

    // bubble on stall, cleared on flush
    always_ff @(posedge clk) begin
        if (rst) begin
            idex_valid <= 1'b0;
        end else begin
            idex_valid <= ifid_valid && !stall && !flush;
        end
    end

    always_ff @(posedge clk) begin
        idex_pc <= ifid_pc;
        idex_instr <= ifid_instr.word;
        idex_a <= rs1_val;
        idex_b <= rs2_val;
        idex_imm <= imm;
        // no destination for store and branch
        idex_rd <= is_we ? ifid_instr.r_view.rd : 5'd0;
        idex_we <= is_we;
        idex_mem_rd <= is_load;
        idex_mem_wr <= is_store;
    end

endmodule

`default_nettype wire

// ==== verilog/execute_stage.sv ====
`default_nettype none

module execute_stage (
    input logic clk,
    input logic rst,
    input logic idex_valid,
    input logic [cpu_pkg::xlen-1:0] idex_pc,
    input logic [cpu_pkg::xlen-1:0] idex_instr,
    input logic [cpu_pkg::xlen-1:0] idex_a,
    input logic [cpu_pkg::xlen-1:0] idex_b,
    input logic [cpu_pkg::xlen-1:0] idex_imm,
    input logic [4:0] idex_rd,
    input logic idex_we,
    input logic idex_mem_rd,
    input logic idex_mem_wr,
    output logic flush,
    output logic [cpu_pkg::xlen-1:0] branch_target,
    output logic exmem_valid,
    output logic [cpu_pkg::xlen-1:0] exmem_pc,
    output logic [cpu_pkg::xlen-1:0] exmem_instr,
    output logic [cpu_pkg::xlen-1:0] exmem_result,
    output logic [cpu_pkg::xlen-1:0] exmem_store_data,
    output logic [4:0] exmem_rd,
    output logic exmem_we,
    output logic exmem_mem_rd,
    output logic exmem_mem_wr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic is_sub;
    logic [cpu_pkg::xlen-1:0] opb;
    logic [cpu_pkg::xlen-1:0] result;

    assign opcode = idex_instr[6:0];
    assign funct3 = idex_instr[14:12];
    // funct7 bit 5 only means sub on r-type
    assign is_sub = (opcode == cpu_pkg::op_rtype) && idex_instr[30];
    assign opb = (opcode == cpu_pkg::op_rtype) ? idex_b : idex_imm;

    // alu, loads and stores fall back to rs1 plus imm
    always_comb begin
        result = idex_a + opb;
        if (opcode == cpu_pkg::op_rtype || opcode == cpu_pkg::op_itype) begin
            case (funct3)
                cpu_pkg::f3_add: result = is_sub ? idex_a - opb : idex_a + opb;
                cpu_pkg::f3_xor: result = idex_a ^ opb;
                cpu_pkg::f3_or: result = idex_a | opb;
                cpu_pkg::f3_and: result = idex_a & opb;
                default: result = idex_a + opb;
            endcase
        end
    end

    // beq resolves here, two younger slots get dropped
    assign flush = idex_valid && (opcode == cpu_pkg::op_branch) && (idex_a == idex_b);
    assign branch_target = idex_pc + idex_imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            exmem_valid <= 1'b0;
        end else begin
            exmem_valid <= idex_valid;
        end
    end

    // ex/mem payload
    always_ff @(posedge clk) begin
        exmem_pc <= idex_pc;
        exmem_instr <= idex_instr;
        exmem_result <= result;
        exmem_store_data <= idex_b;
        exmem_rd <= idex_rd;
        exmem_we <= idex_we;
        exmem_mem_rd <= idex_mem_rd;
        exmem_mem_wr <= idex_mem_wr;
    end

endmodule

`default_nettype wire

// ==== verilog/memory_stage.sv ====
`default_nettype none

module memory_stage (
    input logic clk,
    input logic rst,
    input logic exmem_valid,
    input logic [cpu_pkg::xlen-1:0] exmem_pc,
    input logic [cpu_pkg::xlen-1:0] exmem_instr,
    input logic [cpu_pkg::xlen-1:0] exmem_result,
    input logic [cpu_pkg::xlen-1:0] exmem_store_data,
    input logic [4:0] exmem_rd,
    input logic exmem_we,
    input logic exmem_mem_rd,
    input logic exmem_mem_wr,
    output logic memwb_valid,
    output logic [cpu_pkg::xlen-1:0] memwb_pc,
    output logic [cpu_pkg::xlen-1:0] memwb_instr,
    output logic [4:0] memwb_rd,
    output logic memwb_we,
    output logic [cpu_pkg::xlen-1:0] memwb_wdata
);

    logic [cpu_pkg::xlen-1:0] dmem [0:cpu_pkg::dmem_depth-1];
    logic [cpu_pkg::dmem_aw-1:0] addr;

    // word addressed, low two bits ignored
    assign addr = exmem_result[cpu_pkg::dmem_aw+1:2];

    // store lands at the end of the cycle
    always_ff @(posedge clk) begin
        if (exmem_valid && exmem_mem_wr) begin
            dmem[addr] <= exmem_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memwb_valid <= 1'b0;
        end else begin
            memwb_valid <= exmem_valid;
        end
    end

    // mem/wb payload, load data or alu result
    always_ff @(posedge clk) begin
        memwb_pc <= exmem_pc;
        memwb_instr <= exmem_instr;
        memwb_rd <= exmem_rd;
        memwb_we <= exmem_we;
        memwb_wdata <= exmem_mem_rd ? dmem[addr] : exmem_result;
    end

endmodule

`default_nettype wire

// ==== trace/retire_trace.sv ====
`default_nettype none

module retire_trace (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input logic ifid_valid,
    input logic memwb_valid,
    input logic [cpu_pkg::xlen-1:0] memwb_pc,
    input logic [cpu_pkg::xlen-1:0] memwb_instr,
    input logic [4:0] memwb_rd,
    input logic memwb_we,
    input logic [cpu_pkg::xlen-1:0] memwb_wdata,
    output logic retire_valid,
    output logic [cpu_pkg::seq_w-1:0] retire_seq,
    output logic [cpu_pkg::xlen-1:0] retire_pc,
    output logic [cpu_pkg::xlen-1:0] retire_instr,
    output logic [4:0] retire_rd,
    output logic retire_we,
    output logic [cpu_pkg::xlen-1:0] retire_wdata,
    output logic [cpu_pkg::cycle_w-1:0] retire_fetch_cycle,
    output logic [cpu_pkg::cycle_w-1:0] retire_cycle
);

    logic [cpu_pkg::cycle_w-1:0] cycle_cnt;
    logic [cpu_pkg::seq_w-1:0] seq_cnt;
    // fetch stamps riding alongside if/id, id/ex, ex/mem, mem/wb
    logic [cpu_pkg::cycle_w-1:0] stamp_id;
    logic [cpu_pkg::cycle_w-1:0] stamp_ex;
    logic [cpu_pkg::cycle_w-1:0] stamp_mem;
    logic [cpu_pkg::cycle_w-1:0] stamp_wb;
    logic shadow_ex_valid;
    logic shadow_mem_valid;

    // counter and sequence number start at zero in the first cycle after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_cnt <= '0;
            seq_cnt <= '0;
            shadow_ex_valid <= 1'b0;
            shadow_mem_valid <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + cpu_pkg::cycle_w'(1);
            if (memwb_valid) begin
                seq_cnt <= seq_cnt + cpu_pkg::seq_w'(1);
            end
            // same bubble and clear rule as decode
            shadow_ex_valid <= ifid_valid && !stall && !flush;
            shadow_mem_valid <= shadow_ex_valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stamp chain
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // stamp taken as if/id captures and held with it on stall
        if (!stall) begin
            stamp_id <= cycle_cnt;
        end
        if (ifid_valid && !stall && !flush) begin
            stamp_ex <= stamp_id;
        end
        if (shadow_ex_valid) begin
            stamp_mem <= stamp_ex;
        end
        if (shadow_mem_valid) begin
            stamp_wb <= stamp_mem;
        end
    end

    // retire record straight off mem/wb
    assign retire_valid = memwb_valid;
    assign retire_seq = seq_cnt;
    assign retire_pc = memwb_pc;
    assign retire_instr = memwb_instr;
    assign retire_rd = memwb_rd;
    assign retire_we = memwb_we;
    assign retire_wdata = memwb_wdata;
    assign retire_fetch_cycle = stamp_wb;
    assign retire_cycle = cycle_cnt;

endmodule

`default_nettype wire

// ==== verilog/cpu_core.sv ====
`default_nettype none

module cpu_core (
    input logic clk,
    input logic rst,
    input logic prog_we,
    input logic [cpu_pkg::imem_aw-1:0] prog_addr,
    input cpu_pkg::instr_u prog_data,
    output logic retire_valid,
    output logic [cpu_pkg::seq_w-1:0] retire_seq,
    output logic [cpu_pkg::xlen-1:0] retire_pc,
    output logic [cpu_pkg::xlen-1:0] retire_instr,
    output logic [4:0] retire_rd,
    output logic retire_we,
    output logic [cpu_pkg::xlen-1:0] retire_wdata,
    output logic [cpu_pkg::cycle_w-1:0] retire_fetch_cycle,
    output logic [cpu_pkg::cycle_w-1:0] retire_cycle
);

    // hazard control
    logic stall;
    logic flush;
    logic [cpu_pkg::xlen-1:0] branch_target;

    // if/id
    logic ifid_valid;
    logic [cpu_pkg::xlen-1:0] ifid_pc;
    cpu_pkg::instr_u ifid_instr;

    // id/ex
    logic idex_valid;
    logic [cpu_pkg::xlen-1:0] idex_pc;
    logic [cpu_pkg::xlen-1:0] idex_instr;
    logic [cpu_pkg::xlen-1:0] idex_a;
    logic [cpu_pkg::xlen-1:0] idex_b;
    logic [cpu_pkg::xlen-1:0] idex_imm;
    logic [4:0] idex_rd;
    logic idex_we;
    logic idex_mem_rd;
    logic idex_mem_wr;

    // ex/mem
    logic exmem_valid;
    logic [cpu_pkg::xlen-1:0] exmem_pc;
    logic [cpu_pkg::xlen-1:0] exmem_instr;
    logic [cpu_pkg::xlen-1:0] exmem_result;
    logic [cpu_pkg::xlen-1:0] exmem_store_data;
    logic [4:0] exmem_rd;
    logic exmem_we;
    logic exmem_mem_rd;
    logic exmem_mem_wr;

    // mem/wb, also the register file write port
    logic memwb_valid;
    logic [cpu_pkg::xlen-1:0] memwb_pc;
    logic [cpu_pkg::xlen-1:0] memwb_instr;
    logic [4:0] memwb_rd;
    logic memwb_we;
    logic [cpu_pkg::xlen-1:0] memwb_wdata;

    //////////////////////////////////////////////////////////////////////
    // stages and tracer, all signal names line up with the ports
    //////////////////////////////////////////////////////////////////////

    fetch_stage fetch_stage_inst (.*);

    decode_stage decode_stage_inst (.*);

    execute_stage execute_stage_inst (.*);

    memory_stage memory_stage_inst (.*);

    retire_trace retire_trace_inst (.*);

endmodule

`default_nettype wire

// ==== verif/retire_checker.sv ====
`default_nettype none

module retire_checker (
    input logic clk,
    input logic rst,
    input logic retire_valid,
    input logic [cpu_pkg::seq_w-1:0] retire_seq,
    input logic [cpu_pkg::xlen-1:0] retire_pc,
    input logic [cpu_pkg::xlen-1:0] retire_instr,
    input logic [4:0] retire_rd,
    input logic retire_we,
    input logic [cpu_pkg::xlen-1:0] retire_wdata,
    input logic [cpu_pkg::cycle_w-1:0] retire_fetch_cycle,
    input logic [cpu_pkg::cycle_w-1:0] retire_cycle,
    input logic [cpu_pkg::xlen-1:0] exp_pc,
    input logic [cpu_pkg::xlen-1:0] exp_instr,
    input logic [4:0] exp_rd,
    input logic exp_we,
    input logic [cpu_pkg::xlen-1:0] exp_wdata,
    input logic exp_nohaz,
    input int total,
    output int count,
    output int pass_cnt,
    output int err_cnt
);

    // cycles seen since reset dropped
    int cyc;

    // compare one field against its expected value
    function automatic int differs(input string name, input logic [31:0] actv,
            input logic [31:0] expv);
        if (actv !== expv) begin
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, expv, actv);
            return 1;
        end
        return 0;
    endfunction

    initial begin
        count = 0;
        pass_cnt = 0;
        err_cnt = 0;
        cyc = 0;
    end

    //////////////////////////////////////////////////////////////////////
    // retire port checks on each falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [cpu_pkg::cycle_w-1:0] lat;
        int bad;
        bad = 0;
        lat = retire_cycle - retire_fetch_cycle;
        if (rst) begin
            cyc = 0;
            // nothing may retire while the core is held
            if (retire_valid !== 1'b0) begin
                $display("retire_valid is not low during reset at t=%0t", $time);
                err_cnt = err_cnt + 1;
            end
        end else begin
            if (retire_valid === 1'b1 && count < total) begin
                // seq counts retires from zero
                bad += differs("retire_seq", 32'(retire_seq),
                    32'(count[cpu_pkg::seq_w-1:0]));
                bad += differs("retire_pc", retire_pc, exp_pc);
                bad += differs("retire_instr", retire_instr, exp_instr);
                bad += differs("retire_rd", 32'(retire_rd), 32'(exp_rd));
                bad += differs("retire_we", 32'(retire_we), 32'(exp_we));
                // cycle counter is zero in the first cycle after reset
                bad += differs("retire_cycle", 32'(retire_cycle),
                    32'(cyc[cpu_pkg::cycle_w-1:0]));
                // store and branch carry no write value
                if (exp_we) begin
                    bad += differs("retire_wdata", retire_wdata, exp_wdata);
                end
                // hazard free rows see the bare pipeline depth
                if (exp_nohaz) begin
                    bad += differs("retire_cycle-retire_fetch_cycle", 32'(lat), 32'd4);
                end else if (lat < 16'd4) begin
                    $display("pc %h retired only %0d cycles after fetch at t=%0t",
                        retire_pc, lat, $time);
                    bad += 1;
                end
                $display("retire %0d at pc %h: %s", count, retire_pc,
                    (bad == 0) ? "ok" : "wrong");
                if (bad == 0) begin
                    pass_cnt = pass_cnt + 1;
                end else begin
                    err_cnt = err_cnt + 1;
                end
                count = count + 1;
            end
            cyc = cyc + 1;
        end
    end

endmodule

`default_nettype wire

// ==== verif/cpu_core_tb.sv ====
`default_nettype none

module cpu_core_tb;

    localparam int max_rows = 16;
    // self loop retires expected past the last table row
    localparam int loop_retires = 2;
    localparam int wait_limit = 400;

    logic clk;
    logic rst;
    logic prog_we;
    logic [cpu_pkg::imem_aw-1:0] prog_addr;
    cpu_pkg::instr_u prog_data;
    logic retire_valid;
    logic [cpu_pkg::seq_w-1:0] retire_seq;
    logic [cpu_pkg::xlen-1:0] retire_pc;
    logic [cpu_pkg::xlen-1:0] retire_instr;
    logic [4:0] retire_rd;
    logic retire_we;
    logic [cpu_pkg::xlen-1:0] retire_wdata;
    logic [cpu_pkg::cycle_w-1:0] retire_fetch_cycle;
    logic [cpu_pkg::cycle_w-1:0] retire_cycle;

    // program table, one row per word address
    cpu_pkg::instr_u prog_word [0:max_rows-1];
    logic row_retires [0:max_rows-1];
    logic [4:0] row_rd [0:max_rows-1];
    logic row_we [0:max_rows-1];
    logic [cpu_pkg::xlen-1:0] row_wdata [0:max_rows-1];
    logic row_nohaz [0:max_rows-1];
    int ret_idx [0:max_rows-1];
    int n_rows;
    int n_ret;
    int total;
    int exp_row;
    logic [cpu_pkg::xlen-1:0] exp_pc;
    logic [cpu_pkg::xlen-1:0] exp_instr;
    logic [4:0] exp_rd;
    logic exp_we;
    logic [cpu_pkg::xlen-1:0] exp_wdata;
    logic exp_nohaz;
    int count;
    int pass_cnt;
    int err_cnt;
    int timeouts;
    int cycles;

    cpu_core cpu_core_inst (.*);

    retire_checker retire_checker_inst (.*);

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // instruction encoders
    //////////////////////////////////////////////////////////////////////

    function automatic cpu_pkg::instr_u rtype_word(input logic [6:0] f7, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        cpu_pkg::instr_u w;
        w.r_view.funct7 = f7;
        w.r_view.rs2 = rs2;
        w.r_view.rs1 = rs1;
        w.r_view.funct3 = f3;
        w.r_view.rd = rd;
        w.r_view.opcode = cpu_pkg::op_rtype;
        return w;
    endfunction

    function automatic cpu_pkg::instr_u itype_word(input logic [6:0] op, input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        cpu_pkg::instr_u w;
        w.i_view.imm = imm;
        w.i_view.rs1 = rs1;
        w.i_view.funct3 = f3;
        w.i_view.rd = rd;
        w.i_view.opcode = op;
        return w;
    endfunction

    // sw rs2, imm(rs1)
    function automatic cpu_pkg::instr_u store_word(input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [11:0] imm);
        cpu_pkg::instr_u w;
        w.s_view.imm_hi = imm[11:5];
        w.s_view.rs2 = rs2;
        w.s_view.rs1 = rs1;
        w.s_view.funct3 = 3'b010;
        w.s_view.imm_lo = imm[4:0];
        w.s_view.opcode = cpu_pkg::op_store;
        return w;
    endfunction

    // beq, offset bits scattered as in the b format
    function automatic cpu_pkg::instr_u branch_word(input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [12:0] off);
        cpu_pkg::instr_u w;
        w.s_view.imm_hi = {off[12], off[10:5]};
        w.s_view.rs2 = rs2;
        w.s_view.rs1 = rs1;
        w.s_view.funct3 = 3'b000;
        w.s_view.imm_lo = {off[4:1], off[11]};
        w.s_view.opcode = cpu_pkg::op_branch;
        return w;
    endfunction

    task automatic add_row(input cpu_pkg::instr_u w, input logic ret, input logic [4:0] rd,
            input logic we, input logic [31:0] wd, input logic nh);
        prog_word[n_rows] = w;
        row_retires[n_rows] = ret;
        row_rd[n_rows] = rd;
        row_we[n_rows] = we;
        row_wdata[n_rows] = wd;
        row_nohaz[n_rows] = nh;
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        n_rows = 0;
        n_ret = 0;
        // x1 = 5, x2 = -4, then a write to x0
        add_row(itype_word(cpu_pkg::op_itype, cpu_pkg::f3_add, 5'd1, 5'd0, 12'd5),
            1'b1, 5'd1, 1'b1, 32'h0000_0005, 1'b1);
        add_row(itype_word(cpu_pkg::op_itype, cpu_pkg::f3_add, 5'd2, 5'd0, 12'hffc),
            1'b1, 5'd2, 1'b1, 32'hffff_fffc, 1'b1);
        add_row(itype_word(cpu_pkg::op_itype, cpu_pkg::f3_add, 5'd0, 5'd0, 12'd9),
            1'b1, 5'd0, 1'b1, 32'h0000_0009, 1'b1);
        // add x3 = x1 + x2, stalls on both sources
        add_row(rtype_word(7'h00, cpu_pkg::f3_add, 5'd3, 5'd1, 5'd2),
            1'b1, 5'd3, 1'b1, 32'h0000_0001, 1'b0);
        // sub x4 = x0 - x1, x0 still reads zero
        add_row(rtype_word(7'h20, cpu_pkg::f3_add, 5'd4, 5'd0, 5'd1),
            1'b1, 5'd4, 1'b1, 32'hffff_fffb, 1'b1);
        add_row(rtype_word(7'h00, cpu_pkg::f3_and, 5'd5, 5'd2, 5'd4),
            1'b1, 5'd5, 1'b1, 32'hffff_fff8, 1'b0);
        add_row(rtype_word(7'h00, cpu_pkg::f3_or, 5'd6, 5'd1, 5'd2),
            1'b1, 5'd6, 1'b1, 32'hffff_fffd, 1'b1);
        add_row(rtype_word(7'h00, cpu_pkg::f3_xor, 5'd7, 5'd5, 5'd6),
            1'b1, 5'd7, 1'b1, 32'h0000_0005, 1'b0);
        // store x5 to word 3, load it back into x8
        add_row(store_word(5'd0, 5'd5, 12'd12), 1'b1, 5'd0, 1'b0, 32'h0, 1'b0);
        add_row(itype_word(cpu_pkg::op_load, 3'b010, 5'd8, 5'd0, 12'd12),
            1'b1, 5'd8, 1'b1, 32'hffff_fff8, 1'b1);
        // 5 vs -4 falls through
        add_row(branch_word(5'd1, 5'd2, 13'd8), 1'b1, 5'd0, 1'b0, 32'h0, 1'b1);
        add_row(itype_word(cpu_pkg::op_itype, cpu_pkg::f3_add, 5'd9, 5'd8, 12'd3),
            1'b1, 5'd9, 1'b1, 32'hffff_fffb, 1'b0);
        // self loop, the two words behind it are always flushed
        add_row(branch_word(5'd0, 5'd0, 13'd0), 1'b1, 5'd0, 1'b0, 32'h0, 1'b1);
        add_row(itype_word(cpu_pkg::op_itype, cpu_pkg::f3_add, 5'd10, 5'd0, 12'd123),
            1'b0, 5'd10, 1'b1, 32'h0000_007b, 1'b1);
        add_row(itype_word(cpu_pkg::op_itype, cpu_pkg::f3_add, 5'd11, 5'd0, 12'd456),
            1'b0, 5'd11, 1'b1, 32'h0000_01c8, 1'b1);
        for (int r = 0; r < n_rows; r++) begin
            if (row_retires[r]) begin
                ret_idx[n_ret] = r;
                n_ret = n_ret + 1;
            end
        end
        total = n_ret + loop_retires;
    endtask

    // expected row follows the checker's retire count
    always_comb begin
        if (n_ret == 0) begin
            exp_row = 0;
        end else if (count < n_ret) begin
            exp_row = ret_idx[count];
        end else begin
            exp_row = ret_idx[n_ret-1];
        end
        exp_pc = 32'(exp_row * 4);
        exp_instr = prog_word[exp_row].word;
        exp_rd = row_rd[exp_row];
        exp_we = row_we[exp_row];
        exp_wdata = row_wdata[exp_row];
        exp_nohaz = row_nohaz[exp_row];
    end

    //////////////////////////////////////////////////////////////////////
    // reset with program load, then wait for the retires
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        timeouts = 0;
        cycles = 0;
        build_table();
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            if (i == 15) begin
                rst <= 1'b0;
                prog_we <= 1'b0;
            end else if (i < n_rows) begin
                prog_we <= 1'b1;
                prog_addr <= i[cpu_pkg::imem_aw-1:0];
                prog_data <= prog_word[i];
            end else begin
                prog_we <= 1'b0;
            end
        end
        while (count < total && cycles < wait_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (count < total) begin
            $display("timeout waiting for retire, %0d of %0d seen", count, total);
            timeouts = timeouts + 1;
        end
        $display("retires %0d, passed %0d, failed %0d, timeouts %0d",
            count, pass_cnt, err_cnt, timeouts);
        if (err_cnt == 0 && timeouts == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
common/cpu_pkg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
trace/retire_trace.sv
verilog/cpu_core.sv
verif/retire_checker.sv
verif/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu_core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module cpu_core_tb -o cpu_core_sim

out=$(./obj_dir/cpu_core_sim)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
